//--- logic/csr_settings.svh
// Address map, register offsets, widths and feature identity of the CSR manager
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

// Host MMIO window, byte addressed, 32 words of 64 bits
`define CSR_BASE_ADDR            'h1000
`define CSR_WINDOW_BYTES         256

// Feature header and UID words
`define CSR_OFF_DFH              'h00
`define CSR_OFF_ID_L             'h08
`define CSR_OFF_ID_H             'h10

// Host write registers
`define CSR_OFF_MODE             'h18
`define CSR_OFF_PT_BASE          'h20

// Statistics totals
`define CSR_OFF_STAT_4K_HIT      'h28
`define CSR_OFF_STAT_4K_MISS     'h30
`define CSR_OFF_STAT_2M_HIT      'h38
`define CSR_OFF_STAT_2M_MISS     'h40
`define CSR_OFF_STAT_WALK_BUSY   'h48

// Intermediate counters and flush period
`define STAT_CNT_WIDTH           16
`define STAT_PERIOD_LOG2         10
`define NUM_STATS                5

// Host side
`define REQ_FIFO_DEPTH           64
`define TID_WIDTH                9
// Counted in 4-byte units
`define MMIO_ADDR_WIDTH          16

// Feature identity, next of zero ends the feature list
`define FEATURE_UID              128'h3f6d2a91_5c07_4be2_9a18_d04e7b6c2f55
`define FEATURE_ID               1
`define FEATURE_NEXT             0

`endif

//--- logic/csr_pkg.sv
// Request, response, event, mode, statistics and feature header types
`include "csr_settings.svh"

package csr_pkg;

    // Index of a 64-bit word in the CSR store
    typedef logic [4:0] csr_offset_t;

    // Host address in 4-byte units
    typedef logic [`MMIO_ADDR_WIDTH-1:0] mmio_addr_t;

    typedef struct packed {
        logic                  wr_valid;
        logic                  rd_valid;
        mmio_addr_t            addr;
        logic [`TID_WIDTH-1:0] tid;
        logic [63:0]           data;
    } mmio_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`TID_WIDTH-1:0] tid;
        logic [63:0]           data;
    } mmio_rsp_t;

    // Translation mode register, full 64-bit CSR word
    typedef struct packed {
        logic [61:0] rsvd;
        logic        inval_cache;
        logic        enabled;
    } vtp_mode_t;

    // One-cycle event strobes from the translation block
    typedef struct packed {
        logic hit_4k_c0;
        logic hit_4k_c1;
        logic miss_4k;
        logic hit_2m_c0;
        logic hit_2m_c1;
        logic miss_2m;
        logic walk_busy;
    } vtp_events_t;

    typedef logic [`STAT_CNT_WIDTH-1:0] stat_cnt_t;

    // One statistic, store word and count to add
    typedef struct packed {
        csr_offset_t offset;
        stat_cnt_t   count;
    } stat_entry_t;

    typedef stat_entry_t [0:`NUM_STATS-1] stat_vec_t;

    // Pending host read
    typedef struct packed {
        csr_offset_t           offset;
        logic [`TID_WIDTH-1:0] tid;
    } rd_req_t;

    // Device feature header word
    typedef struct packed {
        logic [3:0]  ftype;
        logic [18:0] rsvd;
        logic        eol;
        logic [23:0] next;
        logic [3:0]  version;
        logic [11:0] id;
    } feature_header_t;

endpackage

//--- logic/mmio_decode.sv
// Decode stage for host MMIO requests
// Write registers and the push of in-window reads
`timescale 1ns/1ns
`include "csr_settings.svh"

module mmio_decode
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  mmio_req_t   mmio_req,
    output vtp_mode_t   vtp_mode,
    output logic [63:0] page_table_base,
    output logic        page_table_base_valid,
    output logic        rd_push,
    output rd_req_t     rd_push_data
);

    // Window limits and write targets in 4-byte units
    localparam mmio_addr_t WIN_LO  = mmio_addr_t'(`CSR_BASE_ADDR >> 2);
    localparam mmio_addr_t WIN_HI  = mmio_addr_t'((`CSR_BASE_ADDR + `CSR_WINDOW_BYTES) >> 2);
    localparam mmio_addr_t MODE_A  = mmio_addr_t'((`CSR_BASE_ADDR + `CSR_OFF_MODE) >> 2);
    localparam mmio_addr_t PT_A    = mmio_addr_t'((`CSR_BASE_ADDR + `CSR_OFF_PT_BASE) >> 2);

    mmio_req_t  req_q;
    logic       in_window;
    logic       mode_wr;
    logic       pt_wr;
    mmio_addr_t addr_off;

    // Input register, only the strobes need clearing
    always_ff @(posedge clk)
    begin
        req_q <= mmio_req;
        if (reset)
        begin
            req_q.wr_valid <= 1'b0;
            req_q.rd_valid <= 1'b0;
        end
    end

    assign in_window = (req_q.addr >= WIN_LO) && (req_q.addr < WIN_HI);
    assign mode_wr   = req_q.wr_valid && (req_q.addr == MODE_A);
    assign pt_wr     = req_q.wr_valid && (req_q.addr == PT_A);

    // Offset from the base, still in 4-byte units
    assign addr_off  = req_q.addr - WIN_LO;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            vtp_mode              <= '0;
            page_table_base_valid <= 1'b0;
            rd_push               <= 1'b0;
        end
        else
        begin
            rd_push <= req_q.rd_valid && in_window;

            if (mode_wr)
            begin
                vtp_mode <= vtp_mode_t'(req_q.data);
            end
            else
            begin
                // Cache invalidate is a single-cycle request
                vtp_mode.inval_cache <= 1'b0;
            end

            // Sticky once the host has given a table
            if (pt_wr)
            begin
                page_table_base_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (pt_wr)
        begin
            page_table_base <= req_q.data;
        end
        // Drop the low bit to get a 64-bit word index
        rd_push_data.offset <= csr_offset_t'(addr_off >> 1);
        rd_push_data.tid    <= req_q.tid;
    end

endmodule

//--- logic/req_fifo.sv
// FIFO for any payload type, no back-pressure toward the writer
`timescale 1ns/1ns

module req_fifo
#(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 64
)
(
    input  logic     clk,
    input  logic     reset,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     not_empty
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;

    // Storage
    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    // Pointers wrap at DEPTH
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Level only moves when one side acts alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign head      = mem[rd_ptr];
    assign not_empty = (count != '0);

endmodule

//--- logic/stat_counters.sv
// Translation event counters with periodic flush toward the sequencer
`timescale 1ns/1ns
`include "csr_settings.svh"

module stat_counters
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  vtp_events_t events,
    input  logic        upd_ready,
    output logic        upd_en,
    output stat_vec_t   upd_vec
);

    // Store word of each statistic, in flush order
    localparam csr_offset_t STAT_OFF [`NUM_STATS] = '{
        csr_offset_t'(`CSR_OFF_STAT_4K_HIT >> 3),
        csr_offset_t'(`CSR_OFF_STAT_4K_MISS >> 3),
        csr_offset_t'(`CSR_OFF_STAT_2M_HIT >> 3),
        csr_offset_t'(`CSR_OFF_STAT_2M_MISS >> 3),
        csr_offset_t'(`CSR_OFF_STAT_WALK_BUSY >> 3)
    };

    logic [`STAT_PERIOD_LOG2:0] period_cnt;
    logic [1:0]                 incr [`NUM_STATS];
    stat_cnt_t                  cnt  [`NUM_STATS];

    // ==================================================
    // Flush timing
    // ==================================================

    // Top bit set means a flush is due, retried until the sequencer is idle
    always_ff @(posedge clk)
    begin
        if (reset || upd_en)
        begin
            period_cnt <= '0;
        end
        else
        begin
            period_cnt <= period_cnt + 1'b1;
        end
    end

    assign upd_en = period_cnt[`STAT_PERIOD_LOG2] && upd_ready;

    // ==================================================
    // Event counting
    // ==================================================

    // Register the events first, hits sum both channels
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `NUM_STATS; i++)
            begin
                incr[i] <= 2'd0;
            end
        end
        else
        begin
            incr[0] <= 2'(events.hit_4k_c0) + 2'(events.hit_4k_c1);
            incr[1] <= 2'(events.miss_4k);
            incr[2] <= 2'(events.hit_2m_c0) + 2'(events.hit_2m_c1);
            incr[3] <= 2'(events.miss_2m);
            incr[4] <= 2'(events.walk_busy);
        end
    end

    // A flush restarts from zero but keeps this cycle's increment
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < `NUM_STATS; i++)
        begin
            if (reset)
            begin
                cnt[i] <= '0;
            end
            else
            begin
                cnt[i] <= (upd_en ? stat_cnt_t'(0) : cnt[i]) + stat_cnt_t'(incr[i]);
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < `NUM_STATS; i++)
        begin
            upd_vec[i].offset = STAT_OFF[i];
            upd_vec[i].count  = cnt[i];
        end
    end

endmodule

//--- logic/csr_store.sv
// CSR word memory with preloaded feature header and UID
// Reads hold the address two cycles before the value is valid
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_store
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        rd_en,
    input  csr_offset_t rd_idx,
    output logic        rd_ready,
    output logic [63:0] rd_data,
    output logic        rd_valid,
    input  logic        wr_en,
    input  csr_offset_t wr_idx,
    input  logic [63:0] wr_data
);

    localparam int CSR_WORDS = `CSR_WINDOW_BYTES / 8;

    localparam logic [127:0] UID = `FEATURE_UID;

    // End of list points past the window, otherwise to the next feature
    localparam feature_header_t FEATURE_DFH = '{
        ftype:   4'd2,
        rsvd:    19'd0,
        eol:     (`FEATURE_NEXT == 0),
        next:    (`FEATURE_NEXT == 0) ? 24'(`CSR_WINDOW_BYTES)
                                      : 24'(`FEATURE_NEXT - `CSR_BASE_ADDR),
        version: 4'd0,
        id:      12'(`FEATURE_ID)
    };

    logic [63:0] mem [0:CSR_WORDS-1];
    logic [1:0]  rd_active;
    csr_offset_t rd_addr;

    // Constant words, statistics start at zero
    initial
    begin
        for (int i = 0; i < CSR_WORDS; i++)
        begin
            mem[i] = '0;
        end
        mem[`CSR_OFF_DFH >> 3]  = FEATURE_DFH;
        mem[`CSR_OFF_ID_L >> 3] = UID[63:0];
        mem[`CSR_OFF_ID_H >> 3] = UID[127:64];
    end

    // Writes only come in while no read is settling
    always @(posedge clk)
    begin
        if (wr_en)
        begin
            mem[wr_idx] <= wr_data;
        end
    end

    // Two-stage read shift, one read at a time
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_active <= 2'b00;
        end
        else
        begin
            rd_active <= {rd_active[0], rd_en};
        end
    end

    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_addr <= rd_idx;
        end
    end

    assign rd_ready = ~(|rd_active);
    assign rd_valid = rd_active[1];
    assign rd_data  = mem[rd_addr];

endmodule

//--- logic/csr_sequencer.sv
// Execute stage, store read arbitration and statistics folding
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_sequencer
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  rd_req_t               rd_head,
    input  logic                  rd_pending,
    output logic                  rd_pop,
    input  logic                  upd_en,
    input  stat_vec_t             upd_vec,
    output logic                  upd_ready,
    output logic                  store_rd_en,
    output csr_offset_t           store_rd_idx,
    input  logic                  store_rd_ready,
    input  logic [63:0]           store_rd_data,
    input  logic                  store_rd_valid,
    output logic                  store_wr_en,
    output csr_offset_t           store_wr_idx,
    output logic [63:0]           store_wr_data,
    output logic                  rsp_capture,
    output logic [`TID_WIDTH-1:0] rsp_tid
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_PROCESS,
        ST_UPDATE,
        ST_WRITEBACK
    } state_t;

    state_t      state;
    stat_vec_t   vec;
    logic        first_pass;
    logic        rd_active;
    logic        host_start;
    logic        stat_start;
    logic [63:0] wr_val;

    // ==================================================
    // Host reads
    // ==================================================

    // Host reads win over statistics
    assign host_start = rd_pending && !rd_active && store_rd_ready;
    assign stat_start = (state == ST_PROCESS) && store_rd_ready && !rd_pending;
    assign rd_pop     = host_start;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_active <= 1'b0;
        end
        else if (host_start)
        begin
            rd_active <= 1'b1;
        end
        else if (store_rd_valid)
        begin
            rd_active <= 1'b0;
        end
    end

    // Tag held for the response
    always_ff @(posedge clk)
    begin
        if (host_start)
        begin
            rsp_tid <= rd_head.tid;
        end
    end

    assign rsp_capture  = rd_active && store_rd_valid;
    assign store_rd_en  = host_start || stat_start;
    assign store_rd_idx = host_start ? rd_head.offset : vec[0].offset;

    // ==================================================
    // Statistics read-modify-write
    // ==================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            first_pass <= 1'b1;
        end
        else
        begin
            case (state)
                ST_IDLE:
                    if (upd_en)
                    begin
                        state <= ST_PROCESS;
                    end
                ST_PROCESS:
                    if (stat_start)
                    begin
                        state <= ST_UPDATE;
                    end
                ST_UPDATE:
                    if (store_rd_valid)
                    begin
                        state <= ST_WRITEBACK;
                    end
                default:
                    // Zero offset after the head marks the end of the list
                    if (store_wr_en)
                    begin
                        if (vec[1].offset != csr_offset_t'(0))
                        begin
                            state <= ST_PROCESS;
                        end
                        else
                        begin
                            state      <= ST_IDLE;
                            first_pass <= 1'b0;
                        end
                    end
            endcase
        end
    end

    // Vector latch, sum and shift
    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && upd_en)
        begin
            vec <= upd_vec;
        end
        else if (store_wr_en)
        begin
            for (int s = 0; s < `NUM_STATS - 1; s++)
            begin
                vec[s] <= vec[s + 1];
            end
            vec[`NUM_STATS-1] <= '0;
        end

        // First pass overwrites whatever the bucket held
        if ((state == ST_UPDATE) && store_rd_valid)
        begin
            wr_val <= first_pass ? 64'(vec[0].count) : store_rd_data + 64'(vec[0].count);
        end
    end

    assign upd_ready     = (state == ST_IDLE);
    assign store_wr_en   = (state == ST_WRITEBACK) && store_rd_ready;
    assign store_wr_idx  = vec[0].offset;
    assign store_wr_data = wr_val;

endmodule

//--- logic/mmio_read_response.sv
// Result stage, one-cycle host read response
`timescale 1ns/1ns
`include "csr_settings.svh"

module mmio_read_response
    import csr_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  capture,
    input  logic [`TID_WIDTH-1:0] tid,
    input  logic [63:0]           data,
    output mmio_rsp_t             mmio_rsp
);

    logic                  rsp_valid;
    logic [`TID_WIDTH-1:0] rsp_tid;
    logic [63:0]           rsp_data;

    // Valid for exactly the cycle after the capture
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= capture;
        end
    end

    // Store value is only good in the capture cycle
    always_ff @(posedge clk)
    begin
        if (capture)
        begin
            rsp_tid  <= tid;
            rsp_data <= data;
        end
    end

    assign mmio_rsp = '{valid: rsp_valid, tid: rsp_tid, data: rsp_data};

endmodule

//--- logic/csr_manager.sv
// CSR manager top level, decode, queue, sequencer, store and response
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_manager
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  mmio_req_t   mmio_req,
    input  vtp_events_t events,
    output mmio_rsp_t   mmio_rsp,
    output vtp_mode_t   vtp_mode,
    output logic [63:0] page_table_base,
    output logic        page_table_base_valid
);

    // Read queue
    logic    rd_push;
    rd_req_t rd_push_data;
    rd_req_t rd_head;
    logic    rd_pending;
    logic    rd_pop;

    // Statistics flush
    logic      upd_en;
    logic      upd_ready;
    stat_vec_t upd_vec;

    // Store ports
    logic        store_rd_en;
    csr_offset_t store_rd_idx;
    logic        store_rd_ready;
    logic [63:0] store_rd_data;
    logic        store_rd_valid;
    logic        store_wr_en;
    csr_offset_t store_wr_idx;
    logic [63:0] store_wr_data;

    // Response handoff
    logic                  rsp_capture;
    logic [`TID_WIDTH-1:0] rsp_tid;

    mmio_decode i_decode (
        .clk, .reset, .mmio_req, .vtp_mode, .page_table_base,
        .page_table_base_valid, .rd_push, .rd_push_data
    );

    req_fifo #(
        .payload_t (rd_req_t),
        .DEPTH     (`REQ_FIFO_DEPTH)
    ) i_req_fifo (
        .clk, .reset,
        .push      (rd_push),
        .push_data (rd_push_data),
        .pop       (rd_pop),
        .head      (rd_head),
        .not_empty (rd_pending)
    );

    stat_counters i_stats (
        .clk, .reset, .events, .upd_ready, .upd_en, .upd_vec
    );

    csr_store i_store (
        .clk, .reset,
        .rd_en    (store_rd_en),
        .rd_idx   (store_rd_idx),
        .rd_ready (store_rd_ready),
        .rd_data  (store_rd_data),
        .rd_valid (store_rd_valid),
        .wr_en    (store_wr_en),
        .wr_idx   (store_wr_idx),
        .wr_data  (store_wr_data)
    );

    csr_sequencer i_sequencer (
        .clk, .reset, .rd_head, .rd_pending, .rd_pop, .upd_en, .upd_vec, .upd_ready,
        .store_rd_en, .store_rd_idx, .store_rd_ready, .store_rd_data, .store_rd_valid,
        .store_wr_en, .store_wr_idx, .store_wr_data, .rsp_capture, .rsp_tid
    );

    mmio_read_response i_response (
        .clk, .reset,
        .capture  (rsp_capture),
        .tid      (rsp_tid),
        .data     (store_rd_data),
        .mmio_rsp
    );

endmodule

//--- test/csr_manager_tb.sv
// Testbench for the CSR manager
// Host writes, feature header, read burst and statistics checked against a store model
`timescale 1ns/1ns
`include "csr_settings.svh"

module csr_manager_tb
    import csr_pkg::*;
();

    typedef logic [`TID_WIDTH-1:0] tid_t;

    // Cycles allowed for outstanding reads to drain
    localparam int RSP_TIMEOUT = 400;
    // Quiet cycles that catch a stray response
    localparam int SETTLE      = 16;
    // One flush period, plus the flush cycle itself
    localparam int PERIOD      = (1 << `STAT_PERIOD_LOG2) + 1;
    localparam int FLUSH_WAIT  = 2 * PERIOD + 100;

    // Window in 4-byte units
    localparam mmio_addr_t WIN_LO     = mmio_addr_t'(`CSR_BASE_ADDR >> 2);
    localparam int         WIN_WORDS4 = `CSR_WINDOW_BYTES / 4;

    localparam logic [127:0] UID = `FEATURE_UID;

    // Statistic byte offsets in flush order
    localparam int STAT_OFF [`NUM_STATS] = '{
        `CSR_OFF_STAT_4K_HIT,
        `CSR_OFF_STAT_4K_MISS,
        `CSR_OFF_STAT_2M_HIT,
        `CSR_OFF_STAT_2M_MISS,
        `CSR_OFF_STAT_WALK_BUSY
    };

    logic        clk = 1'b0;
    logic        reset;
    mmio_req_t   mmio_req;
    vtp_events_t events;
    mmio_rsp_t   mmio_rsp;
    vtp_mode_t   vtp_mode;
    logic [63:0] page_table_base;
    logic        page_table_base_valid;

    // Model of the store contents, 64-bit words
    logic [63:0] ref_mem [0:31];
    mmio_rsp_t   exp_q [$];
    mmio_rsp_t   rsp_q [$];
    int          error_count   = 0;
    int          timeout_count = 0;

    csr_manager i_dut (
        .clk, .reset, .mmio_req, .events, .mmio_rsp, .vtp_mode,
        .page_table_base, .page_table_base_valid
    );

    always #50 clk = ~clk;

    // Responses are stable at the falling edge
    always @(negedge clk)
    begin
        if (!reset && mmio_rsp.valid)
        begin
            rsp_q.push_back(mmio_rsp);
        end
    end

    // ==================================================
    // Checking and reference model
    // ==================================================

    task automatic check_equal(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp)
        else
        begin
            error_count++;
            $display("FAILED %s: expected 'h%0h, actual 'h%0h", name, exp, act);
        end
    endtask

    // Header word from the feature list rule
    function automatic logic [63:0] expected_dfh();
        feature_header_t h;
        h       = '0;
        h.ftype = 4'd2;
        h.eol   = (`FEATURE_NEXT == 0);
        if (h.eol)
        begin
            h.next = 24'(`CSR_WINDOW_BYTES);
        end
        else
        begin
            h.next = 24'(`FEATURE_NEXT - `CSR_BASE_ADDR);
        end
        h.version = 4'd0;
        h.id      = 12'(`FEATURE_ID);
        return h;
    endfunction

    function automatic void store_model_init();
        for (int i = 0; i < 32; i++)
        begin
            ref_mem[i] = '0;
        end
        ref_mem[`CSR_OFF_DFH >> 3]  = expected_dfh();
        ref_mem[`CSR_OFF_ID_L >> 3] = UID[63:0];
        ref_mem[`CSR_OFF_ID_H >> 3] = UID[127:64];
    endfunction

    // ==================================================
    // Host side drivers
    // ==================================================

    task automatic host_write(input mmio_addr_t addr, input logic [63:0] data);
        mmio_req.wr_valid = 1'b1;
        mmio_req.addr     = addr;
        mmio_req.data     = data;
        @(negedge clk);
        mmio_req.wr_valid = 1'b0;
    endtask

    // In-window reads get an expected response from the model
    task automatic host_read(input mmio_addr_t addr, input tid_t tid);
        mmio_rsp_t exp;
        if ((addr >= WIN_LO) && (addr < WIN_LO + WIN_WORDS4))
        begin
            exp.valid = 1'b1;
            exp.tid   = tid;
            exp.data  = ref_mem[(addr - WIN_LO) >> 1];
            exp_q.push_back(exp);
        end
        mmio_req.rd_valid = 1'b1;
        mmio_req.addr     = addr;
        mmio_req.tid      = tid;
        @(negedge clk);
        mmio_req.rd_valid = 1'b0;
    endtask

    // Wait for every expected response, then compare in order
    task automatic collect_responses(input string name);
        int cycles;
        int n;
        cycles = 0;
        while ((rsp_q.size() < exp_q.size()) && (cycles < RSP_TIMEOUT))
        begin
            @(posedge clk);
            cycles++;
        end
        assert (rsp_q.size() >= exp_q.size())
        else
        begin
            timeout_count++;
            $display("Timeout in %s: only %0d of %0d read responses arrived",
                     name, rsp_q.size(), exp_q.size());
        end
        repeat (SETTLE) @(posedge clk);
        check_equal({name, " count"}, exp_q.size(), rsp_q.size());
        n = (rsp_q.size() < exp_q.size()) ? rsp_q.size() : exp_q.size();
        for (int i = 0; i < n; i++)
        begin
            check_equal($sformatf("%s[%0d] tid", name, i), exp_q[i].tid, rsp_q[i].tid);
            check_equal($sformatf("%s[%0d] data", name, i), exp_q[i].data, rsp_q[i].data);
        end
        exp_q.delete();
        rsp_q.delete();
        @(negedge clk);
    endtask

    // Random event bits, hits count both channels
    task automatic drive_events(input int cycles);
        logic [31:0] r;
        vtp_events_t e;
        for (int c = 0; c < cycles; c++)
        begin
            r      = $urandom;
            e      = vtp_events_t'(r[6:0]);
            events = e;
            ref_mem[`CSR_OFF_STAT_4K_HIT >> 3]    += 64'(e.hit_4k_c0) + 64'(e.hit_4k_c1);
            ref_mem[`CSR_OFF_STAT_4K_MISS >> 3]   += 64'(e.miss_4k);
            ref_mem[`CSR_OFF_STAT_2M_HIT >> 3]    += 64'(e.hit_2m_c0) + 64'(e.hit_2m_c1);
            ref_mem[`CSR_OFF_STAT_2M_MISS >> 3]   += 64'(e.miss_2m);
            ref_mem[`CSR_OFF_STAT_WALK_BUSY >> 3] += 64'(e.walk_busy);
            @(negedge clk);
        end
        events = '0;
    endtask

    task automatic read_stats(input string name);
        for (int s = 0; s < `NUM_STATS; s++)
        begin
            host_read(WIN_LO + mmio_addr_t'(STAT_OFF[s] >> 2), tid_t'($urandom));
        end
        collect_responses(name);
    endtask

    // ==================================================
    // Test sequence
    // ==================================================

    initial
    begin
        logic [31:0] r;
        logic [63:0] pt;
        mmio_addr_t  a;
        void'($urandom(84));
        reset    = 1'b1;
        mmio_req = '0;
        events   = '0;
        store_model_init();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        check_equal("reset rsp valid", 64'd0, mmio_rsp.valid);
        check_equal("reset pt valid", 64'd0, page_table_base_valid);
        check_equal("reset vtp mode", 64'd0, vtp_mode);

        // Feature header and UID, one read each
        host_read(WIN_LO + mmio_addr_t'(`CSR_OFF_DFH >> 2), tid_t'($urandom));
        collect_responses("dfh");
        host_read(WIN_LO + mmio_addr_t'(`CSR_OFF_ID_L >> 2), tid_t'($urandom));
        collect_responses("id_l");
        host_read(WIN_LO + mmio_addr_t'(`CSR_OFF_ID_H >> 2), tid_t'($urandom));
        collect_responses("id_h");
        // Upper 4-byte half maps to the same word
        host_read(WIN_LO + mmio_addr_t'(`CSR_OFF_ID_H >> 2) + 1'b1, tid_t'($urandom));
        collect_responses("id_h upper");

        // Mode write lands two cycles after the request
        host_write(WIN_LO + mmio_addr_t'(`CSR_OFF_MODE >> 2), 64'h1);
        check_equal("mode before", 64'h0, vtp_mode);
        @(negedge clk);
        check_equal("mode enabled", 64'h1, vtp_mode);

        pt = {$urandom, $urandom};
        host_write(WIN_LO + mmio_addr_t'(`CSR_OFF_PT_BASE >> 2), pt);
        check_equal("pt valid before", 64'd0, page_table_base_valid);
        @(negedge clk);
        check_equal("pt base", pt, page_table_base);
        check_equal("pt valid", 64'd1, page_table_base_valid);

        // Cache invalidate shows for one cycle only
        host_write(WIN_LO + mmio_addr_t'(`CSR_OFF_MODE >> 2), 64'h3);
        check_equal("inval before", 64'h1, vtp_mode);
        @(negedge clk);
        check_equal("inval pulse", 64'h3, vtp_mode);
        @(negedge clk);
        check_equal("inval cleared", 64'h1, vtp_mode);

        pt = {$urandom, $urandom};
        host_write(WIN_LO + mmio_addr_t'(`CSR_OFF_PT_BASE >> 2), pt);
        @(negedge clk);
        check_equal("pt base second", pt, page_table_base);
        for (int i = 0; i < 4; i++)
        begin
            check_equal("pt valid sticky", 64'd1, page_table_base_valid);
            @(negedge clk);
        end

        // Back-to-back reads, every fifth one outside the window
        for (int i = 0; i < 24; i++)
        begin
            r = $urandom;
            if ((i % 5) == 3)
            begin
                if (r[4])
                begin
                    a = WIN_LO + mmio_addr_t'(WIN_WORDS4) + mmio_addr_t'(r[3:0]);
                end
                else
                begin
                    a = WIN_LO - 1'b1 - mmio_addr_t'(r[3:0]);
                end
            end
            else
            begin
                a = WIN_LO + mmio_addr_t'(r[5:0]);
            end
            host_read(a, tid_t'(r >> 8));
        end
        collect_responses("burst");

        // Totals since reset, then a second round on top
        drive_events(3 * PERIOD);
        repeat (FLUSH_WAIT) @(negedge clk);
        read_stats("stats first");
        drive_events(2 * PERIOD + 37);
        repeat (FLUSH_WAIT) @(negedge clk);
        read_stats("stats second");

        $display("checks failed: %0d, timeouts: %0d", error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0))
        begin
            $display("sim passed");
        end
        else
        begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/csr_pkg.sv
logic/mmio_decode.sv
logic/req_fifo.sv
logic/stat_counters.sv
logic/csr_store.sv
logic/csr_sequencer.sv
logic/mmio_read_response.sv
logic/csr_manager.sv
test/csr_manager_tb.sv

//--- Bender.yml
package:
  name: csr_manager

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/csr_pkg.sv
      - logic/mmio_decode.sv
      - logic/req_fifo.sv
      - logic/stat_counters.sv
      - logic/csr_store.sv
      - logic/csr_sequencer.sv
      - logic/mmio_read_response.sv
      - logic/csr_manager.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/csr_manager_tb.sv
